//--- design/cpu_boot_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared widths, types and block address rules for the boot and
// memory subsystem. modules pull these in with a wildcard import in
// the module body and use scoped names in their port lists.
//////////////////////////////////////////////////////////////////////
package cpu_boot_pkg;

    localparam int word_w      = 32;
    localparam int addr_w      = 16;
    localparam int host_addr_w = 64;
    localparam int num_banks   = 16;     // words per block and per line
    localparam int line_w      = 512;
    localparam int bank_depth  = 1024;   // row = byte addr [15:6]

    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;
    typedef logic [line_w-1:0] line_t;   // bank 0 in the low word

    // host channel opcodes
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        READ   = 2'b01,
        UNUSED = 2'b10,
        WRITE  = 2'b11
    } host_op_t;

    // host address, seen either as a raw word or split into fields
    typedef union packed {
        logic [host_addr_w-1:0] raw;
        struct packed {
            logic [host_addr_w-addr_w-2:0] pad;        // 47 zero bits
            logic                          im_space;   // set for instruction blocks
            addr_t                         local_addr;
        } fields;
    } host_addr_u;

    //////////////////////////////////////////////////////////////////////
    // block base addresses
    //////////////////////////////////////////////////////////////////////

    // data blocks sit in groups of four per 4 KB page
    function automatic addr_t dm_block_addr(input logic [7:0] n);
        addr_t base;
        base = addr_t'((32'(n) / 32'd4 + 32'd1) * 32'h1000);
        if (n[1])
            base = base + addr_t'(16'h0100);
        if (n[0])
            base = base + addr_t'(16'h0040);
        return base;
    endfunction

    // instruction blocks are packed from address zero
    function automatic addr_t im_block_addr(input logic [7:0] n);
        return addr_t'(32'(n) * 32'h40);
    endfunction

endpackage

//--- design/boot_loader.sv
//////////////////////////////////////////////////////////////////////
// boot loader FSM. waits for the host ready level, then pulls all
// data blocks followed by all instruction blocks over the host read
// channel and turns every received word into a memory write strobe.
// boot_done stays high once the last instruction block has landed.
//////////////////////////////////////////////////////////////////////
module boot_loader #(
    parameter int num_dm_blocks = 16,
    parameter int num_im_blocks = 48
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    ready,
    input  logic                    rd_valid,
    input  logic                    tx_done,
    input  cpu_boot_pkg::word_t     ex_wrt_data,
    output cpu_boot_pkg::host_op_t  op,
    output cpu_boot_pkg::host_addr_u ex_addr,
    output logic                    ld_dm_wrt_en,
    output logic                    ld_im_wrt_en,
    output cpu_boot_pkg::addr_t     ld_addr,
    output cpu_boot_pkg::word_t     ld_data,
    output logic                    boot_done
);
    import cpu_boot_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REQ_DM,
        ST_BURST_DM,
        ST_REQ_IM,
        ST_BURST_IM,
        ST_DONE
    } state_t;

    state_t     state, next_state;
    logic [7:0] dm_cnt, im_cnt;     // block being fetched
    addr_t      word_addr;          // address of the next burst word
    addr_t      cur_base;
    logic       in_im, in_req, in_burst;
    logic       dm_last, im_last;

    assign in_im    = (state == ST_REQ_IM) || (state == ST_BURST_IM);
    assign in_req   = (state == ST_REQ_DM) || (state == ST_REQ_IM);
    assign in_burst = (state == ST_BURST_DM) || (state == ST_BURST_IM);
    assign dm_last  = (dm_cnt == 8'(num_dm_blocks - 1));
    assign im_last  = (im_cnt == 8'(num_im_blocks - 1));
    assign cur_base = in_im ? im_block_addr(im_cnt) : dm_block_addr(dm_cnt);

    //////////////////////////////////////////////////////////////////////
    // state and counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            dm_cnt    <= '0;
            im_cnt    <= '0;
            word_addr <= '0;
        end else begin
            state <= next_state;
            if (in_req && rd_valid)
                word_addr <= cur_base + addr_t'(4);   // word 0 goes to the base
            else if (in_burst)
                word_addr <= word_addr + addr_t'(4);
            if (state == ST_BURST_DM && tx_done && !dm_last)
                dm_cnt <= dm_cnt + 8'd1;
            if (state == ST_BURST_IM && tx_done && !im_last)
                im_cnt <= im_cnt + 8'd1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:     if (ready) next_state = ST_REQ_DM;
            ST_REQ_DM:   if (rd_valid) next_state = ST_BURST_DM;
            ST_BURST_DM: begin
                if (tx_done)
                    next_state = dm_last ? ST_REQ_IM : ST_REQ_DM;
            end
            ST_REQ_IM:   if (rd_valid) next_state = ST_BURST_IM;
            ST_BURST_IM: begin
                if (tx_done)
                    next_state = im_last ? ST_DONE : ST_REQ_IM;
            end
            ST_DONE:     next_state = ST_DONE;
            default:     next_state = ST_IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // host request and memory write outputs
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        ex_addr.raw = '0;
        if (in_req || in_burst) begin
            ex_addr.fields.im_space   = in_im;
            ex_addr.fields.local_addr = cur_base;   // held for the whole block
        end
    end

    assign op           = (in_req || in_burst) ? READ : IDLE;
    assign ld_addr      = in_burst ? word_addr : cur_base;
    assign ld_data      = ex_wrt_data;
    assign ld_dm_wrt_en = (state == ST_BURST_DM) || (state == ST_REQ_DM && rd_valid);
    assign ld_im_wrt_en = (state == ST_BURST_IM) || (state == ST_REQ_IM && rd_valid);
    assign boot_done    = (state == ST_DONE);

endmodule

//--- design/dm_port_arbiter.sv
//////////////////////////////////////////////////////////////////////
// data memory port arbiter. the loader owns the banks until boot is
// done, then the accelerator does, with reads ahead of writes. the
// byte address is split here into bank select and row.
//////////////////////////////////////////////////////////////////////
module dm_port_arbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              boot_done,
    input  logic                              ld_dm_wrt_en,
    input  cpu_boot_pkg::addr_t               ld_addr,
    input  cpu_boot_pkg::word_t               ld_data,
    input  logic                              accel_wrt_en,
    input  logic                              accel_rd_en,
    input  cpu_boot_pkg::addr_t               accel_addr,
    input  cpu_boot_pkg::word_t               accel_wrt_data,
    output logic [cpu_boot_pkg::num_banks-1:0] bank_wrt_en,
    output logic [9:0]                        bank_row,
    output cpu_boot_pkg::word_t               bank_wrt_data,
    output logic                              bank_rd_en,
    output logic                              acc_rd_issued,
    output logic                              acc_wrt_issued
);
    import cpu_boot_pkg::*;

    localparam int bank_lsb = 2;
    localparam int row_lsb  = bank_lsb + $clog2(num_banks);

    logic                         accel_owned_q;   // sticky handover flag
    logic                         accel_own;
    addr_t                        sel_addr;
    logic [$clog2(num_banks)-1:0] bank_sel;

    // once handed over the banks never go back to the loader
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            accel_owned_q <= 1'b0;
        else if (boot_done)
            accel_owned_q <= 1'b1;
    end

    assign accel_own      = boot_done | accel_owned_q;
    assign acc_rd_issued  = accel_own & accel_rd_en;
    assign acc_wrt_issued = accel_own & accel_wrt_en & ~accel_rd_en;   // read wins

    assign sel_addr      = accel_own ? accel_addr : ld_addr;
    assign bank_sel      = sel_addr[row_lsb-1:bank_lsb];
    assign bank_row      = sel_addr[addr_w-1:row_lsb];
    assign bank_wrt_data = accel_own ? accel_wrt_data : ld_data;
    assign bank_rd_en    = acc_rd_issued;   // all banks read a full line

    always_comb begin
        bank_wrt_en = '0;
        if (acc_wrt_issued || (!accel_own && ld_dm_wrt_en))
            bank_wrt_en[bank_sel] = 1'b1;   // one word, one bank
    end

endmodule

//--- design/dm_bank.sv
//////////////////////////////////////////////////////////////////////
// one word-wide bank of data memory. write and read happen on the
// clock edge; the read word is held until the next read.
//////////////////////////////////////////////////////////////////////
module dm_bank (
    input  logic                clk,
    input  logic                wrt_en,
    input  logic                rd_en,
    input  logic [9:0]          wrt_row,
    input  logic [9:0]          rd_row,
    input  cpu_boot_pkg::word_t wrt_data,
    output cpu_boot_pkg::word_t rd_data
);
    import cpu_boot_pkg::*;

    word_t mem [bank_depth];

    always_ff @(posedge clk) begin
        if (wrt_en)
            mem[wrt_row] <= wrt_data;
    end

    // registered read, old data on a same-row collision
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_data <= mem[rd_row];
    end

endmodule

//--- design/accel_resp.sv
//////////////////////////////////////////////////////////////////////
// accelerator response stage. delays the issue strobes one cycle so
// they line up with the registered bank data, and gathers the bank
// words into one line with bank 0 in the low word.
//////////////////////////////////////////////////////////////////////
module accel_resp (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                acc_rd_issued,
    input  logic                acc_wrt_issued,
    input  cpu_boot_pkg::word_t bank_rd_data [cpu_boot_pkg::num_banks],
    output logic                accel_rd_valid,
    output logic                accel_wrt_done,
    output cpu_boot_pkg::line_t accel_rd_data
);
    import cpu_boot_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_rd_valid <= 1'b0;
            accel_wrt_done <= 1'b0;
        end else begin
            accel_rd_valid <= acc_rd_issued;    // one pulse per read
            accel_wrt_done <= acc_wrt_issued;
        end
    end

    // line assembly
    always_comb begin
        for (int i = 0; i < num_banks; i++) begin
            accel_rd_data[i*word_w +: word_w] = bank_rd_data[i];
        end
    end

endmodule

//--- design/instr_mem.sv
//////////////////////////////////////////////////////////////////////
// instruction memory. filled word by word by the boot loader and
// read through the fetch port one cycle after the address is seen.
// depth follows the number of instruction blocks.
//////////////////////////////////////////////////////////////////////
module instr_mem #(
    parameter int num_im_blocks = 48
) (
    input  logic                clk,
    input  logic                wrt_en,
    input  cpu_boot_pkg::addr_t wrt_addr,
    input  cpu_boot_pkg::word_t wrt_data,
    input  cpu_boot_pkg::addr_t rd_addr,
    output cpu_boot_pkg::word_t rd_data
);
    import cpu_boot_pkg::*;

    localparam int depth = num_banks * num_im_blocks;
    localparam int idx_w = $clog2(depth);

    word_t            mem [depth];
    logic [idx_w-1:0] wrt_idx, rd_idx;

    assign wrt_idx = wrt_addr[idx_w+1:2];   // byte to word address
    assign rd_idx  = rd_addr[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (wrt_en)
            mem[wrt_idx] <= wrt_data;
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];   // fetch port
    end

endmodule

//--- design/cpu_boot_mem.sv
//////////////////////////////////////////////////////////////////////
// top level of the boot and memory subsystem. the loader fills data
// and instruction memory from the host; after boot_done the
// accelerator writes words and reads lines of data memory and the
// fetch port reads instruction words.
//////////////////////////////////////////////////////////////////////
module cpu_boot_mem #(
    parameter int num_dm_blocks = 16,
    parameter int num_im_blocks = 48
) (
    input  logic                     clk,
    input  logic                     rst_n,
    // host channel
    input  logic                     ready,
    input  logic                     rd_valid,
    input  logic                     tx_done,
    input  cpu_boot_pkg::word_t      ex_wrt_data,
    output cpu_boot_pkg::host_op_t   op,
    output cpu_boot_pkg::host_addr_u ex_addr,
    // accelerator port
    input  logic                     accel_wrt_en,
    input  logic                     accel_rd_en,
    input  cpu_boot_pkg::addr_t      accel_addr,
    input  cpu_boot_pkg::word_t      accel_wrt_data,
    output logic                     accel_wrt_done,
    output logic                     accel_rd_valid,
    output cpu_boot_pkg::line_t      accel_rd_data,
    // fetch port
    input  cpu_boot_pkg::addr_t      im_rd_addr,
    output cpu_boot_pkg::word_t      im_instr,
    output logic                     boot_done
);
    import cpu_boot_pkg::*;

    logic                 ld_dm_wrt_en, ld_im_wrt_en;
    addr_t                ld_addr;
    word_t                ld_data;
    logic [num_banks-1:0] bank_wrt_en;
    logic [9:0]           bank_row;
    word_t                bank_wrt_data;
    logic                 bank_rd_en;
    word_t                bank_rd_data [num_banks];
    logic                 acc_rd_issued, acc_wrt_issued;

    boot_loader #(
        .num_dm_blocks(num_dm_blocks),
        .num_im_blocks(num_im_blocks)
    ) u_loader (
        .clk(clk), .rst_n(rst_n),
        .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .ex_wrt_data(ex_wrt_data), .op(op), .ex_addr(ex_addr),
        .ld_dm_wrt_en(ld_dm_wrt_en), .ld_im_wrt_en(ld_im_wrt_en),
        .ld_addr(ld_addr), .ld_data(ld_data), .boot_done(boot_done)
    );

    instr_mem #(.num_im_blocks(num_im_blocks)) u_imem (
        .clk(clk), .wrt_en(ld_im_wrt_en), .wrt_addr(ld_addr),
        .wrt_data(ld_data), .rd_addr(im_rd_addr), .rd_data(im_instr)
    );

    dm_port_arbiter u_arb (
        .clk(clk), .rst_n(rst_n), .boot_done(boot_done),
        .ld_dm_wrt_en(ld_dm_wrt_en), .ld_addr(ld_addr), .ld_data(ld_data),
        .accel_wrt_en(accel_wrt_en), .accel_rd_en(accel_rd_en),
        .accel_addr(accel_addr), .accel_wrt_data(accel_wrt_data),
        .bank_wrt_en(bank_wrt_en), .bank_row(bank_row),
        .bank_wrt_data(bank_wrt_data), .bank_rd_en(bank_rd_en),
        .acc_rd_issued(acc_rd_issued), .acc_wrt_issued(acc_wrt_issued)
    );

    //////////////////////////////////////////////////////////////////////
    // data memory banks, one word of the line each
    //////////////////////////////////////////////////////////////////////
    for (genvar i = 0; i < num_banks; i++) begin : g_bank
        dm_bank u_bank (
            .clk(clk), .wrt_en(bank_wrt_en[i]), .rd_en(bank_rd_en),
            .wrt_row(bank_row), .rd_row(bank_row),
            .wrt_data(bank_wrt_data), .rd_data(bank_rd_data[i])
        );
    end

    accel_resp u_resp (
        .clk(clk), .rst_n(rst_n),
        .acc_rd_issued(acc_rd_issued), .acc_wrt_issued(acc_wrt_issued),
        .bank_rd_data(bank_rd_data), .accel_rd_valid(accel_rd_valid),
        .accel_wrt_done(accel_wrt_done), .accel_rd_data(accel_rd_data)
    );

endmodule

//--- tests/cpu_boot_mem_chk.sv
//////////////////////////////////////////////////////////////////////
// concurrent checks on the boot and memory top level. bound into the
// top level so it sees the internal write issue strobe.
//////////////////////////////////////////////////////////////////////
module cpu_boot_mem_chk (
    input logic                   clk,
    input logic                   rst_n,
    input cpu_boot_pkg::host_op_t op,
    input logic                   boot_done,
    input logic                   acc_wrt_issued,
    input logic                   accel_wrt_done
);
    import cpu_boot_pkg::*;

    // spare encoding never leaves the loader
    op_never_unused: assert property (
        @(posedge clk) disable iff (!rst_n) op != UNUSED
    ) else $error("op drove the unused encoding");

    boot_done_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) boot_done |=> boot_done
    ) else $error("boot_done fell after rising");

    // done pulse only right after an accepted write
    wrt_done_follows_write: assert property (
        @(posedge clk) disable iff (!rst_n) accel_wrt_done |-> $past(acc_wrt_issued)
    ) else $error("accel_wrt_done without a preceding accepted write");

endmodule

bind cpu_boot_mem cpu_boot_mem_chk u_chk (
    .clk(clk),
    .rst_n(rst_n),
    .op(op),
    .boot_done(boot_done),
    .acc_wrt_issued(acc_wrt_issued),
    .accel_wrt_done(accel_wrt_done)
);

//--- tests/tb_cpu_boot_mem.sv
//////////////////////////////////////////////////////////////////////
// testbench for the boot and memory top level. a host model answers
// the loader's block requests with random words, then the fetch port
// and random accelerator traffic are checked against a reference
// image of both memories kept here.
//////////////////////////////////////////////////////////////////////
module tb_cpu_boot_mem;
    import cpu_boot_pkg::*;

    localparam int n_dm            = 16;
    localparam int n_im            = 48;
    localparam int n_fetch         = 64;
    localparam int n_accel         = 300;
    localparam int watchdog_cycles = (n_dm + n_im) * 25 + 600;

    logic       clk, rst_n;
    logic       ready, rd_valid, tx_done;
    word_t      ex_wrt_data;
    host_op_t   op;
    host_addr_u ex_addr;
    logic       accel_wrt_en, accel_rd_en;
    addr_t      accel_addr;
    word_t      accel_wrt_data;
    logic       accel_wrt_done, accel_rd_valid;
    line_t      accel_rd_data;
    addr_t      im_rd_addr;
    word_t      im_instr;
    logic       boot_done;

    word_t dm_ref [addr_t];   // byte address -> expected word
    word_t im_ref [addr_t];

    cpu_boot_mem u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // memory map of the loaded blocks
    //////////////////////////////////////////////////////////////////////
    function automatic addr_t data_base(input int n);
        return addr_t'(32'h1000 * (n / 4 + 1) + ((n % 4 >= 2) ? 32'h100 : 32'h0)
                       + ((n % 2 == 1) ? 32'h40 : 32'h0));
    endfunction

    function automatic addr_t instr_base(input int n);
        return addr_t'(n * 64);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_on_error(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("%s:\n got %h\n exp %h", what, got, exp));
    endtask

    task automatic check_addr(input host_addr_u got, input host_addr_u exp,
                              input string what);
        if (got.raw !== exp.raw)
            stop_on_error($sformatf("%s: got %h, expected %h", what, got.raw, exp.raw));
    endtask

    task automatic check_op(input host_op_t got, input host_op_t exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("%s: got %s, expected %s", what, got.name(), exp.name()));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_on_error($sformatf("%s: got %b, expected %b", what, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // host and accelerator models
    //////////////////////////////////////////////////////////////////////

    // one block: check the request, stall a little, then 16 words
    task automatic serve_block(input logic im_space, input int n);
        host_addr_u exp_addr;
        addr_t      base;
        word_t      w;
        int         delay;
        base                       = im_space ? instr_base(n) : data_base(n);
        exp_addr.raw               = '0;
        exp_addr.fields.im_space   = im_space;
        exp_addr.fields.local_addr = base;
        delay                      = int'($urandom_range(5, 0));
        check_op(op, READ, "host op during request");
        check_addr(ex_addr, exp_addr, $sformatf("request address of block %0d", n));
        repeat (delay) begin
            @(negedge clk);
            check_addr(ex_addr, exp_addr, "held request address");
        end
        for (int i = 0; i < num_banks; i++) begin
            w           = $urandom;
            rd_valid    = (i == 0);
            tx_done     = (i == num_banks - 1);   // with the last word
            ex_wrt_data = w;
            if (im_space)
                im_ref[base + addr_t'(4 * i)] = w;
            else
                dm_ref[base + addr_t'(4 * i)] = w;
            @(negedge clk);
        end
        rd_valid = 1'b0;
        tx_done  = 1'b0;
    endtask

    // requests before boot must be dropped
    task automatic pre_boot_traffic();
        for (int k = 0; k < 8; k++) begin
            accel_rd_en    = $urandom_range(1, 0) == 1;
            accel_wrt_en   = $urandom_range(1, 0) == 1;
            accel_addr     = data_base(int'($urandom_range(n_dm - 1, 0)));
            accel_wrt_data = $urandom;
            @(negedge clk);
            check_flag(accel_rd_valid, 1'b0, "accel_rd_valid before boot");
            check_flag(accel_wrt_done, 1'b0, "accel_wrt_done before boot");
            check_op(op, IDLE, "host op before ready");
            check_flag(boot_done, 1'b0, "boot_done before ready");
        end
        accel_rd_en  = 1'b0;
        accel_wrt_en = 1'b0;
    endtask

    // one fetch per cycle, result checked a cycle later
    task automatic fetch_reads();
        addr_t a, prev;
        prev = '0;
        for (int k = 0; k <= n_fetch; k++) begin
            if (k > 0)
                check_word(im_instr, im_ref[prev], $sformatf("fetch at %h", prev));
            a          = addr_t'($urandom_range(num_banks * n_im - 1, 0) * 4);
            im_rd_addr = a;
            prev       = a;
            @(negedge clk);
        end
    endtask

    task automatic accel_traffic();
        logic  exp_rd, exp_wr;
        line_t exp_line;
        addr_t a, base;
        int    kind;
        exp_rd   = 1'b0;
        exp_wr   = 1'b0;
        exp_line = '0;
        for (int k = 0; k <= n_accel; k++) begin
            check_flag(accel_rd_valid, exp_rd, "accel_rd_valid");
            check_flag(accel_wrt_done, exp_wr, "accel_wrt_done");
            if (exp_rd)
                check_line(accel_rd_data, exp_line, "accelerator line");
            // 0 write, 1 read, 2 both, 3 idle
            kind = (k == n_accel) ? 3 : int'($urandom_range(3, 0));
            a    = data_base(int'($urandom_range(n_dm - 1, 0)))
                   + addr_t'(4 * $urandom_range(num_banks - 1, 0));
            accel_rd_en    = (kind == 1) || (kind == 2);
            accel_wrt_en   = (kind == 0) || (kind == 2);
            accel_addr     = a;
            accel_wrt_data = $urandom;
            exp_rd         = accel_rd_en;
            exp_wr         = (kind == 0);   // a read beats a write
            if (exp_wr)
                dm_ref[a] = accel_wrt_data;
            if (exp_rd) begin
                base = {a[15:6], 6'b0};
                for (int i = 0; i < num_banks; i++)
                    exp_line[i*word_w +: word_w] = dm_ref[base + addr_t'(4 * i)];
            end
            @(negedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        host_addr_u zero_addr;
        void'($urandom(39));
        zero_addr.raw  = '0;
        rst_n          = 1'b0;
        ready          = 1'b0;
        rd_valid       = 1'b0;
        tx_done        = 1'b0;
        ex_wrt_data    = '0;
        accel_wrt_en   = 1'b0;
        accel_rd_en    = 1'b0;
        accel_addr     = '0;
        accel_wrt_data = '0;
        im_rd_addr     = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_op(op, IDLE, "host op after reset");
        check_addr(ex_addr, zero_addr, "ex_addr after reset");
        check_flag(boot_done, 1'b0, "boot_done after reset");
        pre_boot_traffic();

        ready = 1'b1;
        @(negedge clk);
        for (int n = 0; n < n_dm; n++)
            serve_block(1'b0, n);
        for (int n = 0; n < n_im; n++)
            serve_block(1'b1, n);
        check_flag(boot_done, 1'b1, "boot_done after last block");
        check_op(op, IDLE, "host op after boot");

        fetch_reads();
        accel_traffic();

        $display("PASS: all tests");
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_cycles * 4);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- compile.f
design/cpu_boot_pkg.sv
design/boot_loader.sv
design/dm_port_arbiter.sv
design/dm_bank.sv
design/accel_resp.sv
design/instr_mem.sv
design/cpu_boot_mem.sv
tests/cpu_boot_mem_chk.sv
tests/tb_cpu_boot_mem.sv

//--- Makefile
# Verilator build and run for the boot and memory subsystem

TOP := tb_cpu_boot_mem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "PASS: all tests" sim.log

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
